//--- common/umi_regif_pkg.sv
// umi register target definitions
`default_nettype none

package umi_regif_pkg;

   //##################################################
   // widths
   //##################################################
   localparam int aw = 64;                       // address width
   localparam int cw = 32;                       // command width
   localparam int dw = 32;                       // payload and register width

   //##################################################
   // command fields
   //##################################################
   localparam int opcode_lsb  = 0;               // cmd[4:0]
   localparam int opcode_w    = 5;
   localparam int size_lsb    = 5;               // cmd[7:5], echoed only
   localparam int size_w      = 3;
   localparam int options_lsb = 8;               // cmd[31:8], echoed
   localparam int options_w   = 24;

   //##################################################
   // address decode
   //##################################################
   localparam int grp_offset = 24;               // group field position
   localparam int grp_w      = 4;
   localparam logic [grp_w-1:0] grp_id = 4'h3;   // group this target answers

   localparam int reg_idx_lsb = 2;               // word address
   localparam int reg_idx_w   = 4;
   localparam int num_regs    = 16;

   // request and response opcodes
   typedef enum logic [opcode_w-1:0] {
      op_req_read   = 5'd1,                      // read request
      op_resp_read  = 5'd2,                      // read response
      op_req_write  = 5'd3,                      // acked write
      op_resp_write = 5'd4,                      // write response
      op_req_posted = 5'd5                       // posted write, no response
   } umi_opcode_e;

   // controller states
   typedef enum logic [1:0] {
      st_init   = 2'd0,                          // first cycle after reset
      st_idle   = 2'd1,                          // ready for a request
      st_access = 2'd2,                          // register access, two cycles
      st_resp   = 2'd3                           // response held until ready
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- common/umi_packet_if.sv
// umi packet channel
`timescale 1ns/100ps
`default_nettype none

interface umi_packet_if;

   logic                         valid;      // packet present
   logic                         ready;      // sink can take it
   logic [umi_regif_pkg::cw-1:0] cmd;        // opcode, size, options
   logic [umi_regif_pkg::aw-1:0] dst_addr;
   logic [umi_regif_pkg::aw-1:0] src_addr;
   logic [umi_regif_pkg::dw-1:0] payload;

   // transfer on a rising edge with valid and ready both high,
   // sender holds valid and fields until then

   modport sender (
      output valid,
      output cmd,
      output dst_addr,
      output src_addr,
      output payload,
      input  ready
   );

   modport receiver (
      input  valid,
      input  cmd,
      input  dst_addr,
      input  src_addr,
      input  payload,
      output ready
   );

endinterface

`default_nettype wire

//--- common/reg_access_if.sv
// register bank access port
`timescale 1ns/100ps
`default_nettype none

interface reg_access_if;

   logic                                read;    // load rddata on edge
   logic                                write;   // store wrdata on edge
   logic [umi_regif_pkg::reg_idx_w-1:0] idx;     // register select
   logic [umi_regif_pkg::dw-1:0]        wrdata;
   logic [umi_regif_pkg::dw-1:0]        rddata;  // held until next read

   modport master (
      output read,
      output write,
      output idx,
      output wrdata,
      input  rddata
   );

   modport bank (
      input  read,
      input  write,
      input  idx,
      input  wrdata,
      output rddata
   );

endinterface

`default_nettype wire

//--- umi_regif/umi_regif_ctrl.sv
// umi register target controller
`timescale 1ns/100ps
`default_nettype none

module umi_regif_ctrl (
   input  wire logic          clk,
   input  wire logic          nreset,
   umi_packet_if.receiver     req,          // valid and ready only
   umi_packet_if.sender       resp,         // valid and ready only
   output      logic          accept,       // latch request fields
   output      logic          access_en,    // register access cycle
   input  wire logic          hit,          // group and opcode match
   input  wire logic          needs_resp    // read or acked write
);

   umi_regif_pkg::ctrl_state_e state;
   umi_regif_pkg::ctrl_state_e state_nxt;
   logic                       settle;       // second st_access cycle

   //##################################################
   // handshake and strobes
   //##################################################
   assign req.ready  = (state == umi_regif_pkg::st_idle);
   assign resp.valid = (state == umi_regif_pkg::st_resp);
   assign accept     = req.valid & req.ready;   // edge A
   assign access_en  = (state == umi_regif_pkg::st_access) & ~settle; // edge A+1

   //##################################################
   // next state
   //##################################################
   always_comb begin
      state_nxt = state;
      case (state)
         umi_regif_pkg::st_init: begin
            state_nxt = umi_regif_pkg::st_idle;       // one cycle after release
         end
         umi_regif_pkg::st_idle: begin
            if (accept) begin
               state_nxt = umi_regif_pkg::st_access;
            end
         end
         umi_regif_pkg::st_access: begin
            // rddata valid in the second cycle so the decision waits for edge A+2
            if (settle) begin
               if (hit && needs_resp) begin
                  state_nxt = umi_regif_pkg::st_resp;
               end else begin
                  state_nxt = umi_regif_pkg::st_idle;  // posted, dropped
               end
            end
         end
         umi_regif_pkg::st_resp: begin
            if (resp.ready) begin
               state_nxt = umi_regif_pkg::st_idle;     // response taken
            end
         end
         default: begin
            state_nxt = umi_regif_pkg::st_init;
         end
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state  <= umi_regif_pkg::st_init;
         settle <= 1'b0;
      end else begin
         state  <= state_nxt;
         settle <= (state == umi_regif_pkg::st_access) & ~settle;  // toggles once
      end
   end

   //##################################################
   // assertions
   //##################################################
   // response must not be withdrawn before the sink takes it
   a_resp_hold: assert property (
      @(posedge clk) disable iff (!nreset)
      resp.valid && !resp.ready |=> resp.valid
   );

   // decode of the latched request holds until the decision edge
   a_decode_stable: assert property (
      @(posedge clk) disable iff (!nreset)
      access_en |=> $stable(hit) && $stable(needs_resp)
   );

endmodule

`default_nettype wire

//--- umi_regif/umi_packet_codec.sv
// umi request latch and response builder
`timescale 1ns/100ps
`default_nettype none

module umi_packet_codec (
   input  wire logic          clk,
   input  wire logic          nreset,
   umi_packet_if.receiver     req,          // fields only
   umi_packet_if.sender       resp,         // fields only
   reg_access_if.master       regs,
   input  wire logic          accept,       // capture request
   input  wire logic          access_en,    // one cycle register strobe
   output      logic          hit,          // valid opcode in our group
   output      logic          needs_resp    // read or acked write
);

   logic [umi_regif_pkg::cw-1:0] cmd_q;      // latched request
   logic [umi_regif_pkg::aw-1:0] dst_q;
   logic [umi_regif_pkg::aw-1:0] src_q;
   logic [umi_regif_pkg::dw-1:0] payload_q;

   umi_regif_pkg::umi_opcode_e   opcode;
   umi_regif_pkg::umi_opcode_e   resp_op;
   logic                         is_read;
   logic                         is_write;     // acked or posted
   logic                         grp_match;

   //##################################################
   // request capture on edge A
   //##################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cmd_q <= '0;                            // opcode 0 decodes as no hit
      end else if (accept) begin
         cmd_q <= req.cmd;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dst_q     <= req.dst_addr;
         src_q     <= req.src_addr;
         payload_q <= req.payload;
      end
   end

   //##################################################
   // decode
   //##################################################
   assign opcode = umi_regif_pkg::umi_opcode_e'(
                      cmd_q[umi_regif_pkg::opcode_lsb +: umi_regif_pkg::opcode_w]);

   assign is_read   = (opcode == umi_regif_pkg::op_req_read);
   assign is_write  = (opcode == umi_regif_pkg::op_req_write) |
                      (opcode == umi_regif_pkg::op_req_posted);
   assign grp_match = (dst_q[umi_regif_pkg::grp_offset +: umi_regif_pkg::grp_w] ==
                       umi_regif_pkg::grp_id);

   assign hit        = grp_match & (is_read | is_write);  // unknown ops dropped
   assign needs_resp = is_read | (opcode == umi_regif_pkg::op_req_write);

   // register port
   assign regs.read   = access_en & hit & is_read;
   assign regs.write  = access_en & hit & is_write;
   assign regs.idx    = dst_q[umi_regif_pkg::reg_idx_lsb +: umi_regif_pkg::reg_idx_w];
   assign regs.wrdata = payload_q;

   //##################################################
   // response fields
   //##################################################
   assign resp_op = is_read ? umi_regif_pkg::op_resp_read : umi_regif_pkg::op_resp_write;

   assign resp.cmd      = {cmd_q[umi_regif_pkg::options_lsb +: umi_regif_pkg::options_w],
                           cmd_q[umi_regif_pkg::size_lsb +: umi_regif_pkg::size_w],
                           resp_op};                 // options and size echoed
   assign resp.dst_addr = src_q;                     // back to requester
   assign resp.src_addr = dst_q;
   assign resp.payload  = is_read ? regs.rddata : '0;

endmodule

`default_nettype wire

//--- src/reg_file.sv
// sixteen entry register bank
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  wire logic   clk,
   input  wire logic   nreset,
   reg_access_if.bank  regs
);

   logic [umi_regif_pkg::dw-1:0] mem [umi_regif_pkg::num_regs];   // register array

   //##################################################
   // write port
   //##################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < umi_regif_pkg::num_regs; i++) begin
            mem[i] <= '0;                        // all registers start at zero
         end
      end else if (regs.write) begin
         mem[regs.idx] <= regs.wrdata;
      end
   end

   //##################################################
   // registered read port
   //##################################################
   always_ff @(posedge clk) begin
      if (regs.read) begin
         regs.rddata <= mem[regs.idx];           // held until next read
      end
   end

   // the controller issues one access per request
   a_rd_wr_excl: assert property (
      @(posedge clk) disable iff (!nreset)
      !(regs.read && regs.write)
   );

endmodule

`default_nettype wire

//--- src/umi_regif_top.sv
// umi register target top level
`timescale 1ns/100ps
`default_nettype none

module umi_regif_top (
   input  wire logic                         clk,
   input  wire logic                         nreset,
   // request channel
   input  wire logic                         udev_req_valid,
   input  wire logic [umi_regif_pkg::cw-1:0] udev_req_cmd,
   input  wire logic [umi_regif_pkg::aw-1:0] udev_req_dst_addr,
   input  wire logic [umi_regif_pkg::aw-1:0] udev_req_src_addr,
   input  wire logic [umi_regif_pkg::dw-1:0] udev_req_payload,
   output      logic                         udev_req_ready,
   // response channel
   output      logic                         udev_resp_valid,
   output      logic [umi_regif_pkg::cw-1:0] udev_resp_cmd,
   output      logic [umi_regif_pkg::aw-1:0] udev_resp_dst_addr,
   output      logic [umi_regif_pkg::aw-1:0] udev_resp_src_addr,
   output      logic [umi_regif_pkg::dw-1:0] udev_resp_payload,
   input  wire logic                         udev_resp_ready
);

   umi_packet_if req ();                         // outside to target
   umi_packet_if resp ();                        // target to outside
   reg_access_if regs ();

   logic accept;
   logic access_en;
   logic hit;
   logic needs_resp;

   //##################################################
   // port mapping
   //##################################################
   assign req.valid         = udev_req_valid;
   assign req.cmd           = udev_req_cmd;
   assign req.dst_addr      = udev_req_dst_addr;
   assign req.src_addr      = udev_req_src_addr;
   assign req.payload       = udev_req_payload;
   assign udev_req_ready    = req.ready;

   assign udev_resp_valid    = resp.valid;
   assign udev_resp_cmd      = resp.cmd;
   assign udev_resp_dst_addr = resp.dst_addr;
   assign udev_resp_src_addr = resp.src_addr;
   assign udev_resp_payload  = resp.payload;
   assign resp.ready         = udev_resp_ready;

   //##################################################
   // blocks
   //##################################################
   umi_regif_ctrl umi_regif_ctrl_i (
      .clk        (clk),
      .nreset     (nreset),
      .req        (req),
      .resp       (resp),
      .accept     (accept),
      .access_en  (access_en),
      .hit        (hit),
      .needs_resp (needs_resp)
   );

   umi_packet_codec umi_packet_codec_i (
      .clk        (clk),
      .nreset     (nreset),
      .req        (req),
      .resp       (resp),
      .regs       (regs),
      .accept     (accept),
      .access_en  (access_en),
      .hit        (hit),
      .needs_resp (needs_resp)
   );

   reg_file reg_file_i (
      .clk    (clk),
      .nreset (nreset),
      .regs   (regs)
   );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic nreset
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                     // 10 ns period
   end

   initial begin
      nreset = 1'b0;
      repeat (8) @(posedge clk);                 // eight cycles in reset
      #1;
      nreset = 1'b1;
   end

endmodule

`default_nettype wire

//--- dv/tb_umi_regif.sv
// umi register target testbench
`timescale 1ns/100ps
`default_nettype none

module tb_umi_regif;

   localparam int ready_limit = 100;             // cycles to wait for req_ready
   localparam int idle_limit  = 200;

   logic        clk;
   logic        nreset;
   logic        udev_req_valid;
   logic [31:0] udev_req_cmd;
   logic [63:0] udev_req_dst_addr;
   logic [63:0] udev_req_src_addr;
   logic [31:0] udev_req_payload;
   logic        udev_req_ready;
   logic        udev_resp_valid;
   logic [31:0] udev_resp_cmd;
   logic [63:0] udev_resp_dst_addr;
   logic [63:0] udev_resp_src_addr;
   logic [31:0] udev_resp_payload;
   logic        udev_resp_ready;

   logic [191:0] resp_now;                       // cmd, dst, src, payload
   logic [191:0] exp_q [$];                      // expected responses in order
   string        name_q [$];
   logic [31:0]  shadow [16];                    // reference register copy
   string        cur_test;
   logic         bp_en;                          // random back-pressure on
   int           exp_count;
   int           resp_count;

   assign resp_now = {udev_resp_cmd, udev_resp_dst_addr, udev_resp_src_addr, udev_resp_payload};

   tb_clock_gen tb_clock_gen_i (.clk (clk), .nreset (nreset));

   umi_regif_top umi_regif_top_i (
      .clk                (clk),
      .nreset             (nreset),
      .udev_req_valid     (udev_req_valid),
      .udev_req_cmd       (udev_req_cmd),
      .udev_req_dst_addr  (udev_req_dst_addr),
      .udev_req_src_addr  (udev_req_src_addr),
      .udev_req_payload   (udev_req_payload),
      .udev_req_ready     (udev_req_ready),
      .udev_resp_valid    (udev_resp_valid),
      .udev_resp_cmd      (udev_resp_cmd),
      .udev_resp_dst_addr (udev_resp_dst_addr),
      .udev_resp_src_addr (udev_resp_src_addr),
      .udev_resp_payload  (udev_resp_payload),
      .udev_resp_ready    (udev_resp_ready)
   );

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "stopped on first error");
   endtask

   task automatic check_value(input string test, input string field,
                              input logic [191:0] want, input logic [191:0] act);
      assert (act === want) else
         fail_stop($sformatf("ERROR %s: %s expected %0h actual %0h", test, field, want, act));
   endtask

   //##################################################
   // reference model
   //##################################################
   function automatic logic expect_resp(input logic [31:0] cmd, input logic [63:0] dst,
                                        input logic [63:0] src, input logic [31:0] payload,
                                        output logic [191:0] want);
      logic [4:0] op;
      logic [3:0] idx;
      logic       is_rd;
      logic       is_wr;
      logic       hit;
      op    = cmd[4:0];
      idx   = dst[5:2];                          // word address selects register
      is_rd = (op == umi_regif_pkg::op_req_read);
      is_wr = (op == umi_regif_pkg::op_req_write) || (op == umi_regif_pkg::op_req_posted);
      hit   = (dst[27:24] == umi_regif_pkg::grp_id) && (is_rd || is_wr);
      want  = '0;
      if (hit && is_wr) begin
         shadow[idx] = payload;
      end
      if (hit && is_rd) begin
         want = {cmd[31:5], umi_regif_pkg::op_resp_read, src, dst, shadow[idx]};
      end else if (hit && op == umi_regif_pkg::op_req_write) begin
         want = {cmd[31:5], umi_regif_pkg::op_resp_write, src, dst, 32'h0};
      end
      return hit && (is_rd || op == umi_regif_pkg::op_req_write);  // posted gets none
   endfunction

   function automatic logic [31:0] rand_cmd(input logic [4:0] op);
      logic [31:0] cmd;
      cmd      = $urandom;                       // random size and options
      cmd[4:0] = op;
      return cmd;
   endfunction

   function automatic logic [63:0] target_addr(input logic [3:0] idx, input logic [3:0] grp);
      logic [63:0] addr;
      addr        = {$urandom, $urandom};
      addr[27:24] = grp;
      addr[5:2]   = idx;
      addr[1:0]   = 2'b00;
      return addr;
   endfunction

   //##################################################
   // request driver
   //##################################################
   task automatic send_req(input logic [31:0] cmd, input logic [63:0] dst,
                           input logic [63:0] src, input logic [31:0] payload);
      int           waited;
      logic [191:0] want;
      @(posedge clk);
      #1;
      udev_req_valid    = 1'b1;
      udev_req_cmd      = cmd;
      udev_req_dst_addr = dst;
      udev_req_src_addr = src;
      udev_req_payload  = payload;
      waited = 0;
      @(negedge clk);
      while (!udev_req_ready && waited < ready_limit) begin
         @(negedge clk);
         waited++;
      end
      assert (udev_req_ready) else
         fail_stop($sformatf("%s: request not accepted within %0d cycles", cur_test, waited));
      @(posedge clk);                            // accept edge
      #1;
      udev_req_valid = 1'b0;
      if (expect_resp(cmd, dst, src, payload, want)) begin
         exp_q.push_back(want);
         name_q.push_back(cur_test);
         exp_count++;
      end
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      @(negedge clk);
      while ((exp_q.size() != 0 || !udev_req_ready) && waited < idle_limit) begin
         @(negedge clk);
         waited++;
      end
      assert (exp_q.size() == 0 && udev_req_ready) else
         fail_stop($sformatf("%s: %0d responses still missing", cur_test, exp_q.size()));
   endtask

   // resp_ready with random stalls
   initial begin
      int hold;
      udev_resp_ready = 1'b0;
      hold = 0;
      forever begin
         @(posedge clk);
         #1;
         if (!bp_en) begin
            udev_resp_ready = 1'b1;
         end else if (hold > 0) begin
            udev_resp_ready = 1'b0;
            hold--;
         end else if ($urandom_range(0, 1) == 0) begin
            udev_resp_ready = 1'b0;
            hold = $urandom_range(0, 5);         // stall for a few cycles
         end else begin
            udev_resp_ready = 1'b1;
         end
      end
   end

   //##################################################
   // response checker
   //##################################################
   always @(negedge clk) begin : resp_check
      logic [191:0] want;
      logic [191:0] held;
      logic         stalled;
      string        name;
      if (nreset === 1'b1) begin
         assert (!(udev_req_ready && udev_resp_valid)) else
            fail_stop("request channel open while a response is pending");
         if (stalled) begin                      // last cycle valid without ready
            name = (name_q.size() > 0) ? name_q[0] : cur_test;
            check_value(name, "resp_valid under back-pressure", 192'(1), 192'(udev_resp_valid));
            check_value(name, "held response", held, resp_now);
         end
         if (udev_resp_valid && udev_resp_ready) begin
            assert (exp_q.size() > 0) else
               fail_stop("response seen when none was expected");
            want = exp_q.pop_front();
            name = name_q.pop_front();
            check_value(name, "resp_cmd", 192'(want[191:160]), 192'(udev_resp_cmd));
            check_value(name, "resp_dst_addr", 192'(want[159:96]), 192'(udev_resp_dst_addr));
            check_value(name, "resp_src_addr", 192'(want[95:32]), 192'(udev_resp_src_addr));
            check_value(name, "resp_payload", 192'(want[31:0]), 192'(udev_resp_payload));
            resp_count++;
         end
         stalled = udev_resp_valid && !udev_resp_ready;
         held    = resp_now;
      end else begin
         stalled = 1'b0;
      end
   end

   //##################################################
   // test sequence
   //##################################################
   initial begin
      int         waited;
      int         kind;
      logic [4:0] op;
      logic [3:0] grp;
      void'($urandom(32'h4f97_d2e9));
      udev_req_valid    = 1'b0;
      udev_req_cmd      = '0;
      udev_req_dst_addr = '0;
      udev_req_src_addr = '0;
      udev_req_payload  = '0;
      bp_en      = 1'b0;
      exp_count  = 0;
      resp_count = 0;
      for (int i = 0; i < 16; i++) begin
         shadow[i] = '0;                         // bank clears on reset
      end

      cur_test = "reset";
      waited = 0;
      while (nreset !== 1'b1 && waited < 20) begin
         @(negedge clk);
         if (nreset === 1'b0) begin
            check_value(cur_test, "req_ready", 192'(0), 192'(udev_req_ready));
            check_value(cur_test, "resp_valid", 192'(0), 192'(udev_resp_valid));
         end
         waited++;
      end
      assert (nreset === 1'b1) else fail_stop("reset was never released");
      waited = 0;
      while (!udev_req_ready && waited < 4) begin
         @(negedge clk);
         waited++;
      end
      assert (udev_req_ready) else fail_stop("req_ready did not rise after reset release");

      cur_test = "write_read";
      for (int i = 0; i < 16; i++) begin
         send_req(rand_cmd(umi_regif_pkg::op_req_write), target_addr(i[3:0], 4'h3),
                  {$urandom, $urandom}, $urandom);
      end
      for (int i = 0; i < 16; i++) begin
         send_req(rand_cmd(umi_regif_pkg::op_req_read), target_addr(i[3:0], 4'h3),
                  {$urandom, $urandom}, $urandom);
      end

      cur_test = "posted";
      send_req(rand_cmd(umi_regif_pkg::op_req_posted), target_addr(4'd5, 4'h3), 64'h11, $urandom);
      send_req(rand_cmd(umi_regif_pkg::op_req_posted), target_addr(4'd9, 4'h3), 64'h22, $urandom);
      send_req(rand_cmd(umi_regif_pkg::op_req_read), target_addr(4'd5, 4'h3), 64'h33, '0);
      send_req(rand_cmd(umi_regif_pkg::op_req_read), target_addr(4'd9, 4'h3), 64'h44, '0);

      cur_test = "dropped";
      send_req(rand_cmd(umi_regif_pkg::op_req_write), target_addr(4'd1, 4'h7), 64'h55, $urandom);
      send_req(rand_cmd(umi_regif_pkg::op_req_read), target_addr(4'd2, 4'h0), 64'h66, '0);
      send_req(rand_cmd(5'd2), target_addr(4'd3, 4'h3), 64'h77, $urandom);
      send_req(rand_cmd(5'd0), target_addr(4'd4, 4'h3), 64'h88, $urandom);
      send_req(rand_cmd(5'd12), target_addr(4'd6, 4'h3), 64'h99, $urandom);
      for (int i = 0; i < 16; i++) begin
         send_req(rand_cmd(umi_regif_pkg::op_req_read), target_addr(i[3:0], 4'h3),
                  {$urandom, $urandom}, '0);
      end
      wait_idle();

      cur_test = "back_pressure";
      bp_en = 1'b1;
      for (int i = 0; i < 16; i++) begin
         op = (i % 2 == 0) ? umi_regif_pkg::op_req_write : umi_regif_pkg::op_req_read;
         send_req(rand_cmd(op), target_addr(4'(i / 2), 4'h3), {$urandom, $urandom}, $urandom);
      end

      cur_test = "random_mix";
      for (int n = 0; n < 200; n++) begin
         kind = $urandom_range(0, 9);
         grp  = ($urandom_range(0, 4) == 0) ? 4'($urandom_range(0, 15)) : umi_regif_pkg::grp_id;
         case (kind)
            0, 1, 2: op = umi_regif_pkg::op_req_read;
            3, 4, 5: op = umi_regif_pkg::op_req_write;
            6, 7:    op = umi_regif_pkg::op_req_posted;
            default: op = 5'($urandom_range(6, 31));  // unknown opcode
         endcase
         send_req(rand_cmd(op), target_addr(4'($urandom_range(0, 15)), grp),
                  {$urandom, $urandom}, $urandom);
      end
      wait_idle();

      if (resp_count == exp_count && exp_q.size() == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         fail_stop($sformatf("ERROR final: response count expected %0d actual %0d",
                             exp_count, resp_count));
      end
   end

endmodule

`default_nettype wire

//--- umi_regif.f
common/umi_regif_pkg.sv
common/umi_packet_if.sv
common/reg_access_if.sv
umi_regif/umi_regif_ctrl.sv
umi_regif/umi_packet_codec.sv
src/reg_file.sv
src/umi_regif_top.sv
dv/tb_clock_gen.sv
dv/tb_umi_regif.sv

//--- run_sim.sh
#!/bin/sh
# build and run the umi_regif regression with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_umi_regif \
   -f umi_regif.f \
   --Mdir obj_dir -o sim_umi_regif
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_umi_regif 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
